// File: verilog/pcs_defs.svh
// --------------------
// pcs lane constants
// block width, marker period, transmit credits and marker bytes
// --------------------
`ifndef PCS_DEFS_SVH
`define PCS_DEFS_SVH

// 64b/66b coded block
`define PCS_BLOCK_BITS 66

// output slots per marker interval, marker included
`define PCS_AM_PERIOD 16

// transmit buffer depth, also the initial upstream credit
`define PCS_CREDITS 4

// marker bytes of this lane
`define PCS_AM_M0 8'hC1
`define PCS_AM_M1 8'h68
`define PCS_AM_M2 8'h21

// control sync header, bit 0 = 1 and bit 1 = 0
`define PCS_SYNC_CTRL 2'b10

`endif

// File: verilog/pcs_block_pkg.sv
// --------------------
// coded block types
// block, sync header, parity and marker field
// --------------------
`include "pcs_defs.svh"

package pcs_block_pkg;

   typedef logic [0:`PCS_BLOCK_BITS-1] block_t;   // bit 0 first on the wire
   typedef logic [0:1]                 sync_t;    // bits 0 and 1 of a block
   typedef logic [7:0]                 bip_t;
   typedef logic [7:0]                 am_byte_t;

   // byte k sits at bits 2+8k .. 9+8k, bit j of the byte at 2+8k+j
   function automatic am_byte_t get_byte(block_t blk, int k);
      am_byte_t value;
      for (int j = 0; j < 8; j++)
      begin
         value[j] = blk[2+8*k+j];
      end
      return value;
   endfunction

   function automatic block_t put_byte(block_t blk, int k, am_byte_t value);
      block_t result;
      result = blk;
      for (int j = 0; j < 8; j++)
      begin
         result[2+8*k+j] = value[j];
      end
      return result;
   endfunction

endpackage

// File: verilog/pcs_lane_pkg.sv
// --------------------
// lane control types
// lock states, slot position, credits and error count
// --------------------
package pcs_lane_pkg;

   // receive marker lock
   typedef enum logic [1:0]
   {
      HUNT     = 2'd0,
      VERIFY   = 2'd1,
      LOCKED   = 2'd2
   } lock_state_t;

   // position inside a marker interval, 0 is the marker
   typedef logic [3:0]  slot_count_t;

   // credit or buffer occupancy, 0 up to the buffer depth
   typedef logic [2:0]  credit_t;

   // saturating parity error count
   typedef logic [15:0] err_count_t;

endpackage

// File: verilog/bip_calculator.sv
// --------------------
// bip calculator
// running interleaved parity over coded blocks,
// restarted from all ones at each marker
// --------------------
`include "pcs_defs.svh"

module bip_calculator
   import pcs_block_pkg::*;
#(
   parameter int NB_DATA_CODED = `PCS_BLOCK_BITS
)
(
   input  logic   i_clock,
   input  logic   i_reset,
   input  block_t i_data,
   input  logic   i_enable,
   input  logic   i_valid,
   input  logic   i_start_of_lane,
   input  logic   i_am_insert,
   output bip_t   o_bip3,
   output bip_t   o_bip7
);

   localparam int NB_BYTES = (NB_DATA_CODED - 2) / 8;

   bip_t    bip;
   bip_t    bip_next;
   sync_t   sync_hdr;

   assign sync_hdr = i_data[0:1];
   assign o_bip3   = bip;
   assign o_bip7   = ~bip;

   always_comb
   begin
      // a marker block starts a fresh interval and is part of it
      bip_next = (i_am_insert || i_start_of_lane) ? '1 : bip;
      for (int k = 0; k < NB_BYTES; k++)
      begin
         bip_next = bip_next ^ get_byte(i_data, k);
      end
      bip_next[3] = bip_next[3] ^ sync_hdr[0];
      bip_next[4] = bip_next[4] ^ sync_hdr[1];
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
         bip <= '1;
      else if (i_enable && i_valid)
         bip <= bip_next;
   end

endmodule

// File: verilog/am_inserter.sv
// --------------------
// alignment marker inserter
// credit fed block buffer, one output slot per cycle,
// marker with bip fields at slot 0 of each interval
// --------------------
`include "pcs_defs.svh"

module am_inserter
   import pcs_block_pkg::*;
   import pcs_lane_pkg::*;
(
   input  logic   i_clock,
   input  logic   i_reset,
   input  logic   i_lane_enable,
   input  block_t i_block,
   input  logic   i_valid,
   output logic   o_credit,
   output block_t o_block,
   output logic   o_valid
);

   localparam int          PTR_W     = $clog2(`PCS_CREDITS);
   localparam slot_count_t SLOT_LAST = slot_count_t'(`PCS_AM_PERIOD - 1);

   block_t           fifo_mem [`PCS_CREDITS];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   credit_t          fill;
   logic             lane_en_q;
   logic             lane_start;
   slot_count_t      slot_q;
   slot_count_t      slot_cur;
   logic             send_am;
   logic             send_data;
   block_t           am_block;
   block_t           tx_block;
   logic             tx_valid;
   bip_t             bip3;
   bip_t             bip7;

   assign lane_start = i_lane_enable && !lane_en_q;
   assign slot_cur   = lane_start ? '0 : slot_q;     // enable edge restarts the interval
   assign send_am    = i_lane_enable && (slot_cur == '0);
   assign send_data  = i_lane_enable && (slot_cur != '0) && (fill != '0);

   always_comb
   begin
      am_block       = '0;
      am_block[0:1]  = `PCS_SYNC_CTRL;
      am_block       = put_byte(am_block, 0, `PCS_AM_M0);
      am_block       = put_byte(am_block, 1, `PCS_AM_M1);
      am_block       = put_byte(am_block, 2, `PCS_AM_M2);
      am_block       = put_byte(am_block, 3, bip3);  // parity of the interval just closed
      am_block       = put_byte(am_block, 4, ~am_byte_t'(`PCS_AM_M0));
      am_block       = put_byte(am_block, 5, ~am_byte_t'(`PCS_AM_M1));
      am_block       = put_byte(am_block, 6, ~am_byte_t'(`PCS_AM_M2));
      am_block       = put_byte(am_block, 7, bip7);
   end

   assign tx_block = send_am ? am_block : fifo_mem[rd_ptr];
   assign tx_valid = send_am || send_data;

   // buffer storage
   always_ff @(posedge i_clock)
   begin
      if (i_valid)
         fifo_mem[wr_ptr] <= i_block;
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fill      <= '0;
         lane_en_q <= 1'b0;
         slot_q    <= '0;
         o_valid   <= 1'b0;
         o_credit  <= 1'b0;
      end
      else
      begin
         lane_en_q <= i_lane_enable;
         if (i_valid)
            wr_ptr <= (wr_ptr == PTR_W'(`PCS_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
         if (send_data)
            rd_ptr <= (rd_ptr == PTR_W'(`PCS_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
         fill <= fill + credit_t'(i_valid) - credit_t'(send_data);
         if (tx_valid)
            slot_q <= (slot_cur == SLOT_LAST) ? '0 : slot_cur + 1'b1;
         else
            slot_q <= slot_cur;                       // empty buffer holds the slot
         o_valid  <= tx_valid;
         o_credit <= send_data;                       // one credit back per block read
      end
   end

   always_ff @(posedge i_clock)
   begin
      o_block <= tx_block;
   end

   bip_calculator #(
      .NB_DATA_CODED   (`PCS_BLOCK_BITS)
   ) bip_calculator_inst (
      .i_clock         (i_clock),
      .i_reset         (i_reset),
      .i_data          (tx_block),
      .i_enable        (i_lane_enable),
      .i_valid         (tx_valid),
      .i_start_of_lane (lane_start),
      .i_am_insert     (send_am),
      .o_bip3          (bip3),
      .o_bip7          (bip7)
   );

   // upstream keeps to its credits, so a full buffer sees no new block
   a_no_overflow : assert property (@(posedge i_clock) disable iff (i_reset)
      i_valid |-> (fill != credit_t'(`PCS_CREDITS)));

endmodule

// File: verilog/am_checker.sv
// --------------------
// alignment marker checker
// marker lock, bip check with error count,
// marker removal from the receive stream
// --------------------
`include "pcs_defs.svh"

module am_checker
   import pcs_block_pkg::*;
   import pcs_lane_pkg::*;
(
   input  logic       i_clock,
   input  logic       i_reset,
   input  block_t     i_block,
   input  logic       i_valid,
   output block_t     o_block,
   output logic       o_valid,
   output logic       o_locked,
   output logic       o_bip_error,
   output err_count_t o_bip_error_count
);

   localparam slot_count_t SLOT_LAST = slot_count_t'(`PCS_AM_PERIOD - 1);

   lock_state_t   state;
   slot_count_t   slot;
   logic          missed;
   logic          is_am;
   logic          at_am_slot;
   logic          start_lane;
   logic          bip_enable;
   logic          bip_mismatch;
   bip_t          bip3;
   bip_t          bip7;
   sync_t         sync_hdr;

   assign sync_hdr = i_block[0:1];

   // full marker pattern, bip bytes excluded
   assign is_am = (sync_hdr == `PCS_SYNC_CTRL)
               && (get_byte(i_block, 0) == `PCS_AM_M0)
               && (get_byte(i_block, 1) == `PCS_AM_M1)
               && (get_byte(i_block, 2) == `PCS_AM_M2)
               && (get_byte(i_block, 4) == ~am_byte_t'(`PCS_AM_M0))
               && (get_byte(i_block, 5) == ~am_byte_t'(`PCS_AM_M1))
               && (get_byte(i_block, 6) == ~am_byte_t'(`PCS_AM_M2));

   assign at_am_slot   = i_valid && (state != HUNT) && (slot == '0);  // expected marker
   assign start_lane   = i_valid && (state == HUNT) && is_am;
   assign bip_enable   = (state != HUNT) || start_lane;
   assign bip_mismatch = (get_byte(i_block, 3) != bip3) || (get_byte(i_block, 7) != bip7);
   assign o_locked     = (state == LOCKED);

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         state             <= HUNT;
         slot              <= '0;
         missed            <= 1'b0;
         o_valid           <= 1'b0;
         o_bip_error       <= 1'b0;
         o_bip_error_count <= '0;
      end
      else
      begin
         o_valid     <= i_valid && (state == LOCKED) && (slot != '0);
         o_bip_error <= 1'b0;
         if (i_valid && (state != HUNT))
            slot <= (slot == SLOT_LAST) ? '0 : slot + 1'b1;
         case (state)
            HUNT:
            begin
               missed <= 1'b0;
               if (start_lane)
               begin
                  state <= VERIFY;
                  slot  <= slot_count_t'(1);
               end
            end
            VERIFY:
            begin
               if (at_am_slot)
                  state <= is_am ? LOCKED : HUNT;
            end
            LOCKED:
            begin
               if (at_am_slot && is_am)
               begin
                  missed <= 1'b0;
                  if (bip_mismatch)
                  begin
                     o_bip_error <= 1'b1;
                     if (o_bip_error_count != '1)
                        o_bip_error_count <= o_bip_error_count + 1'b1;  // saturates
                  end
               end
               else if (at_am_slot)
               begin
                  missed <= 1'b1;
                  if (missed)
                     state <= HUNT;   // second miss in a row
               end
            end
            default:
               state <= HUNT;
         endcase
      end
   end

   always_ff @(posedge i_clock)
   begin
      o_block <= i_block;
   end

   bip_calculator #(
      .NB_DATA_CODED   (`PCS_BLOCK_BITS)
   ) bip_calculator_inst (
      .i_clock         (i_clock),
      .i_reset         (i_reset),
      .i_data          (i_block),
      .i_enable        (bip_enable),
      .i_valid         (i_valid),
      .i_start_of_lane (start_lane),
      .i_am_insert     (at_am_slot),
      .o_bip3          (bip3),
      .o_bip7          (bip7)
   );

   // data only leaves while locked, lock is left only on a marker slot
   a_valid_locked : assert property (@(posedge i_clock) disable iff (i_reset)
      $rose(o_valid) |-> o_locked);

endmodule

// File: verilog/pcs_lane_endpoint.sv
// --------------------
// pcs lane endpoint
// transmit marker insertion and receive marker check of one lane
// --------------------
`include "pcs_defs.svh"

module pcs_lane_endpoint
   import pcs_block_pkg::*;
   import pcs_lane_pkg::*;
(
   input  logic       i_clock,
   input  logic       i_reset,
   input  logic       i_lane_enable,
   // transmit
   input  block_t     i_tx_block,
   input  logic       i_tx_valid,
   output logic       o_tx_credit,
   output block_t     o_tx_block,
   output logic       o_tx_valid,
   // receive
   input  block_t     i_rx_block,
   input  logic       i_rx_valid,
   output block_t     o_rx_block,
   output logic       o_rx_valid,
   output logic       o_rx_locked,
   output logic       o_bip_error,
   output err_count_t o_bip_error_count
);

   am_inserter am_inserter_inst (
      .i_clock       (i_clock),
      .i_reset       (i_reset),
      .i_lane_enable (i_lane_enable),
      .i_block       (i_tx_block),
      .i_valid       (i_tx_valid),
      .o_credit      (o_tx_credit),
      .o_block       (o_tx_block),
      .o_valid       (o_tx_valid)
   );

   // receive side runs whenever blocks arrive, the lane enable is tx only
   am_checker am_checker_inst (
      .i_clock           (i_clock),
      .i_reset           (i_reset),
      .i_block           (i_rx_block),
      .i_valid           (i_rx_valid),
      .o_block           (o_rx_block),
      .o_valid           (o_rx_valid),
      .o_locked          (o_rx_locked),
      .o_bip_error       (o_bip_error),
      .o_bip_error_count (o_bip_error_count)
   );

endmodule

// File: sim/pcs_lane_monitor.sv
// --------------------
// pcs lane monitor
// reference model of credits, transmit markers with parity
// and receive lock, compared with every DUT output
// --------------------
`include "pcs_defs.svh"

module pcs_lane_monitor
   import pcs_block_pkg::*;
   import pcs_lane_pkg::*;
#(
   parameter int NUM_BLOCKS = 2000
)
(
   input  logic       i_clock,
   input  logic       i_reset,
   input  block_t     i_tx_block,
   input  logic       i_tx_valid,
   input  logic       i_tx_credit,
   input  block_t     i_tx_out_block,
   input  logic       i_tx_out_valid,
   input  block_t     i_rx_block,
   input  logic       i_rx_valid,
   input  block_t     i_rx_out_block,
   input  logic       i_rx_out_valid,
   input  logic       i_rx_locked,
   input  logic       i_bip_error,
   input  err_count_t i_bip_error_count,
   output int         o_data_seen
);

   localparam int PERIOD = `PCS_AM_PERIOD;

   block_t      sent_q [$];      // data accepted upstream in arrival order
   int          outstanding;
   int          tx_slot;
   bip_t        tx_bip;
   lock_state_t rx_state;
   int          rx_slot;
   logic        rx_miss;
   bip_t        rx_bip;
   logic        rx_valid_exp;
   block_t      rx_block_exp;
   logic        bip_error_exp;
   err_count_t  err_model;
   int          lock_drops;
   int          data_seen     = 0;
   int          credit_errors = 0;
   int          tx_errors     = 0;
   int          rx_errors     = 0;
   int          other_errors  = 0;

   assign o_data_seen = data_seen;

   function automatic am_byte_t byte_at(block_t blk, int k);
      am_byte_t value;
      for (int j = 0; j < 8; j++)
      begin
         value[j] = blk[2+8*k+j];
      end
      return value;
   endfunction

   // interleaved parity with sync bits on parity bits 3 and 4
   function automatic bip_t fold_block(bip_t acc, block_t blk);
      bip_t result;
      result = acc;
      for (int k = 0; k < 8; k++)
      begin
         result = result ^ byte_at(blk, k);
      end
      result[3] = result[3] ^ blk[0];
      result[4] = result[4] ^ blk[1];
      return result;
   endfunction

   function automatic logic is_marker(block_t blk);
      return (blk[0:1] == `PCS_SYNC_CTRL)
          && (byte_at(blk, 0) == `PCS_AM_M0) && (byte_at(blk, 1) == `PCS_AM_M1)
          && (byte_at(blk, 2) == `PCS_AM_M2)
          && (byte_at(blk, 4) == ~am_byte_t'(`PCS_AM_M0))
          && (byte_at(blk, 5) == ~am_byte_t'(`PCS_AM_M1))
          && (byte_at(blk, 6) == ~am_byte_t'(`PCS_AM_M2));
   endfunction

   function automatic block_t marker_block(bip_t bip);
      block_t   blk;
      am_byte_t fields [8];
      fields[0] = `PCS_AM_M0;
      fields[1] = `PCS_AM_M1;
      fields[2] = `PCS_AM_M2;
      fields[3] = bip;
      fields[4] = ~am_byte_t'(`PCS_AM_M0);
      fields[5] = ~am_byte_t'(`PCS_AM_M1);
      fields[6] = ~am_byte_t'(`PCS_AM_M2);
      fields[7] = ~bip;
      blk[0:1]  = `PCS_SYNC_CTRL;
      for (int k = 0; k < 8; k++)
      begin
         for (int j = 0; j < 8; j++)
         begin
            blk[2+8*k+j] = fields[k][j];
         end
      end
      return blk;
   endfunction

   task automatic value_mismatch(input string name, input logic [65:0] expected,
                                 input logic [65:0] actual, inout int counter);
      $display("CHECK FAILED %s expected %h got %h at %0t", name, expected, actual, $time);
      counter++;
   endtask

   task automatic report_failure(input string text, inout int counter);
      $display("%s at %0t", text, $time);
      counter++;
   endtask

   task automatic clear_model();
      sent_q.delete();
      outstanding   = 0;
      tx_slot       = 0;
      tx_bip        = '1;
      rx_state      = HUNT;
      rx_slot       = 0;
      rx_miss       = 1'b0;
      rx_bip        = '1;
      rx_valid_exp  = 1'b0;
      rx_block_exp  = '0;
      bip_error_exp = 1'b0;
      err_model     = '0;
      lock_drops    = 0;
      data_seen     = 0;
   endtask

   task automatic check_reset_values();
      if ((i_tx_out_valid !== 1'b0) || (i_tx_credit !== 1'b0) || (i_rx_out_valid !== 1'b0)
          || (i_rx_locked !== 1'b0) || (i_bip_error !== 1'b0) || (i_bip_error_count !== '0))
         report_failure("an output is not cleared while reset is held", other_errors);
   endtask

   task automatic check_transmit();
      block_t expected;
      bip_t   bip7_exp;
      logic   credit_exp;
      if (i_tx_credit)
         outstanding--;
      if (i_tx_valid)
      begin
         sent_q.push_back(i_tx_block);
         outstanding++;
      end
      if (outstanding > `PCS_CREDITS)
         report_failure("upstream holds more outstanding blocks than credits allow",
                        credit_errors);
      if (outstanding < 0)
         report_failure("a credit came back for a block that was never sent", credit_errors);
      credit_exp = i_tx_out_valid && (tx_slot != 0);   // one credit per data block out
      if (i_tx_credit !== credit_exp)
         value_mismatch("o_tx_credit", 66'(credit_exp), 66'(i_tx_credit), credit_errors);
      if (i_tx_out_valid)
      begin
         if (tx_slot == 0)
         begin
            bip7_exp = ~tx_bip;
            if (byte_at(i_tx_out_block, 3) !== tx_bip)
               value_mismatch("o_tx_block BIP3", 66'(tx_bip), 66'(byte_at(i_tx_out_block, 3)),
                              tx_errors);
            if (byte_at(i_tx_out_block, 7) !== bip7_exp)
               value_mismatch("o_tx_block BIP7", 66'(bip7_exp), 66'(byte_at(i_tx_out_block, 7)),
                              tx_errors);
            expected = marker_block(tx_bip);
            if (i_tx_out_block !== expected)
               value_mismatch("o_tx_block marker", expected, i_tx_out_block, tx_errors);
            tx_bip = fold_block(8'hFF, i_tx_out_block);
         end
         else if (sent_q.size() == 0)
            report_failure("a data block left the transmitter that was never sent", tx_errors);
         else
         begin
            expected = sent_q.pop_front();
            if (i_tx_out_block !== expected)
               value_mismatch("o_tx_block data", expected, i_tx_out_block, tx_errors);
            tx_bip = fold_block(tx_bip, i_tx_out_block);
            data_seen++;
         end
         tx_slot = (tx_slot + 1) % PERIOD;
      end
   endtask

   task automatic check_receive();
      logic marker_seen;
      logic fields_bad;
      logic locked_exp;
      bip_t bip7_exp;
      locked_exp = (rx_state == LOCKED);
      if (i_rx_locked !== locked_exp)
         value_mismatch("o_rx_locked", 66'(locked_exp), 66'(i_rx_locked), rx_errors);
      if (i_rx_out_valid !== rx_valid_exp)
         value_mismatch("o_rx_valid", 66'(rx_valid_exp), 66'(i_rx_out_valid), rx_errors);
      if (rx_valid_exp && (i_rx_out_block !== rx_block_exp))
         value_mismatch("o_rx_block", rx_block_exp, i_rx_out_block, rx_errors);
      if (i_bip_error !== bip_error_exp)
         value_mismatch("o_bip_error", 66'(bip_error_exp), 66'(i_bip_error), rx_errors);
      if (i_bip_error_count !== err_model)
         value_mismatch("o_bip_error_count", 66'(err_model), 66'(i_bip_error_count), rx_errors);
      rx_valid_exp  = 1'b0;
      bip_error_exp = 1'b0;
      if (i_rx_valid)
      begin
         marker_seen  = is_marker(i_rx_block);
         bip7_exp     = ~rx_bip;
         fields_bad   = (byte_at(i_rx_block, 3) != rx_bip) || (byte_at(i_rx_block, 7) != bip7_exp);
         rx_valid_exp = (rx_state == LOCKED) && (rx_slot != 0);   // markers are stripped
         rx_block_exp = i_rx_block;
         if (rx_state == HUNT)
         begin
            if (marker_seen)
            begin
               rx_state = VERIFY;
               rx_slot  = 1;
               rx_miss  = 1'b0;
               rx_bip   = fold_block(8'hFF, i_rx_block);
            end
         end
         else
         begin
            if (rx_slot == 0)
            begin
               if (rx_state == VERIFY)
                  rx_state = marker_seen ? LOCKED : HUNT;
               else if (marker_seen)
               begin
                  rx_miss = 1'b0;
                  if (fields_bad)
                  begin
                     bip_error_exp = 1'b1;
                     if (err_model != '1)
                        err_model++;
                  end
               end
               else if (rx_miss)
               begin
                  rx_state = HUNT;   // second expected marker missing
                  lock_drops++;
               end
               else
                  rx_miss = 1'b1;
               rx_bip = fold_block(8'hFF, i_rx_block);
            end
            else
               rx_bip = fold_block(rx_bip, i_rx_block);
            rx_slot = (rx_slot + 1) % PERIOD;
         end
      end
   endtask

   task automatic final_report(output int total);
      if (data_seen != NUM_BLOCKS)
         report_failure("not every data block sent upstream came out of the transmitter",
                        other_errors);
      if (err_model == '0)
         report_failure("no parity error was seen while the lane was locked", other_errors);
      if (lock_drops == 0)
         report_failure("the receive lock was never lost", other_errors);
      if (rx_state != LOCKED)
         report_failure("the receive side is not locked at the end of the run", other_errors);
      total = credit_errors + tx_errors + rx_errors + other_errors;
      $display("errors: credit %0d, transmit %0d, receive %0d, other %0d (parity errors %0d)",
               credit_errors, tx_errors, rx_errors, other_errors, err_model);
   endtask

   // outputs and inputs are both settled at the falling edge
   always @(negedge i_clock)
   begin
      if (i_reset)
      begin
         check_reset_values();
         clear_model();
      end
      else
      begin
         check_transmit();
         check_receive();
      end
   end

endmodule

// File: sim/tb_pcs_lane.sv
// --------------------
// pcs lane testbench
// credited random blocks into the transmit side, transmit output
// looped back to receive with bit errors and corrupted markers
// --------------------
`include "pcs_defs.svh"

module tb_pcs_lane
   import pcs_block_pkg::*;
   import pcs_lane_pkg::*;
();

   localparam int NUM_BLOCKS   = 2000;
   localparam int RESET_CYCLES = 16;
   localparam int TIMEOUT      = (NUM_BLOCKS * 2 + 400) * 20;
   localparam int MISS_ONE     = 50;   // interval with a single bad marker
   localparam int MISS_TWO     = 80;   // first of two bad markers in a row

   logic       clock;
   logic       reset;
   logic       lane_enable;
   block_t     tx_block;
   logic       tx_valid;
   logic       tx_credit;
   block_t     tx_out_block;
   logic       tx_out_valid;
   block_t     rx_block;
   logic       rx_valid;
   block_t     rx_out_block;
   logic       rx_out_valid;
   logic       rx_locked;
   logic       bip_error;
   err_count_t bip_error_count;
   int         data_seen;
   int         total_errors;
   int         credits;
   int         sent;
   int         tx_index;
   int         flip_slot;
   int         flip_bit;

   initial clock = 1'b0;
   always #10 clock = ~clock;

   pcs_lane_endpoint pcs_lane_endpoint_inst (
      .i_clock           (clock),
      .i_reset           (reset),
      .i_lane_enable     (lane_enable),
      .i_tx_block        (tx_block),
      .i_tx_valid        (tx_valid),
      .o_tx_credit       (tx_credit),
      .o_tx_block        (tx_out_block),
      .o_tx_valid        (tx_out_valid),
      .i_rx_block        (rx_block),
      .i_rx_valid        (rx_valid),
      .o_rx_block        (rx_out_block),
      .o_rx_valid        (rx_out_valid),
      .o_rx_locked       (rx_locked),
      .o_bip_error       (bip_error),
      .o_bip_error_count (bip_error_count)
   );

   pcs_lane_monitor #(
      .NUM_BLOCKS        (NUM_BLOCKS)
   ) monitor_inst (
      .i_clock           (clock),
      .i_reset           (reset),
      .i_tx_block        (tx_block),
      .i_tx_valid        (tx_valid),
      .i_tx_credit       (tx_credit),
      .i_tx_out_block    (tx_out_block),
      .i_tx_out_valid    (tx_out_valid),
      .i_rx_block        (rx_block),
      .i_rx_valid        (rx_valid),
      .i_rx_out_block    (rx_out_block),
      .i_rx_out_valid    (rx_out_valid),
      .i_rx_locked       (rx_locked),
      .i_bip_error       (bip_error),
      .i_bip_error_count (bip_error_count),
      .o_data_seen       (data_seen)
   );

   function automatic block_t random_data_block();
      block_t blk;
      blk[0:1]   = 2'b01;   // data sync header
      blk[2:33]  = $urandom();
      blk[34:65] = $urandom();
      return blk;
   endfunction

   // upstream side, one block per credit
   task automatic drive_upstream();
      if (tx_credit)
         credits++;
      if ((sent < NUM_BLOCKS) && (credits > 0) && ($urandom_range(3, 0) != 0))
      begin
         tx_block = random_data_block();
         tx_valid = 1'b1;
         credits--;
         sent++;
      end
      else
         tx_valid = 1'b0;
   endtask

   // one cycle loopback register with error injection
   task automatic drive_loopback();
      block_t looped;
      int     slot;
      int     interval;
      looped = tx_out_block;
      if (tx_out_valid)
      begin
         slot     = tx_index % `PCS_AM_PERIOD;
         interval = tx_index / `PCS_AM_PERIOD;
         if (slot == 0)
         begin
            if ((interval == MISS_ONE) || (interval == MISS_TWO) || (interval == MISS_TWO + 1))
               looped[2] = ~looped[2];               // bit 0 of M0
            flip_slot = 1 + $urandom_range(14, 0);
            flip_bit  = 2 + $urandom_range(63, 0);  // payload only
         end
         else if (((interval % 16) == 7) && (slot == flip_slot))
            looped[flip_bit] = ~looped[flip_bit];
         tx_index++;
      end
      rx_block = looped;
      rx_valid = tx_out_valid;
   endtask

   task automatic step_cycle();
      @(posedge clock);
      #2;
      drive_upstream();
      drive_loopback();
   endtask

   initial
   begin
      void'($urandom(32'hb078));
      reset       = 1'b1;
      lane_enable = 1'b0;
      tx_block    = '0;
      tx_valid    = 1'b0;
      rx_block    = '0;
      rx_valid    = 1'b0;
      credits     = `PCS_CREDITS;
      sent        = 0;
      tx_index    = 0;
      flip_slot   = 0;
      flip_bit    = 2;
      repeat (RESET_CYCLES) @(posedge clock);
      #2;
      reset       = 1'b0;
      lane_enable = 1'b1;
      while ((sent < NUM_BLOCKS) || (data_seen < NUM_BLOCKS))
      begin
         step_cycle();
      end
      repeat (4) step_cycle();   // loopback plus receive latency
      monitor_inst.final_report(total_errors);
      if (total_errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      #(TIMEOUT);
      $display("watchdog expired after %0d time units, the run did not complete", TIMEOUT);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: files.f
+incdir+verilog
verilog/pcs_block_pkg.sv
verilog/pcs_lane_pkg.sv
verilog/bip_calculator.sv
verilog/am_inserter.sv
verilog/am_checker.sv
verilog/pcs_lane_endpoint.sv
sim/pcs_lane_monitor.sv
sim/tb_pcs_lane.sv

// File: Makefile
# Verilator build and run for the pcs lane testbench

SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_pcs_lane
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log
SOURCES  = $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
